// File: Makefile
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_mem_stage: all.f hdl/*.sv sim/*.sv include/*.svh
	verilator --binary --timing -f all.f --top-module tb_mem_stage -o Vtb_mem_stage

# The log decides the result, a missing pass line fails the target
run: obj_dir/Vtb_mem_stage
	rm -f $(LOG)
	-./obj_dir/Vtb_mem_stage | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

lint:
	verilator --lint-only --timing -f all.f --top-module tb_mem_stage
	verilator --lint-only -Iinclude hdl/mem_pkg.sv hdl/ex_mem.sv hdl/mem.sv \
		hdl/mem_wb.sv hdl/byte_ram.sv hdl/mem_stage_top.sv --top-module mem_stage_top

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
+incdir+include
hdl/mem_pkg.sv
hdl/ex_mem.sv
hdl/mem.sv
hdl/mem_wb.sv
hdl/byte_ram.sv
hdl/mem_stage_top.sv
sim/tb_mem_stage.sv

// File: hdl/byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module byte_ram (
	input  wire                clk,
	input  wire [`ADDR_W-1:0]  addr_i,
	input  wire                we_i,
	input  wire [`BYTE_W-1:0]  wdata_i,
	output logic [`BYTE_W-1:0] rdata_o
);

	logic [`BYTE_W-1:0] ram_q [0:(1 << `RAM_DEPTH_LOG2)-1];
	logic [`RAM_DEPTH_LOG2-1:0] idx;

	assign idx = addr_i[`RAM_DEPTH_LOG2-1:0]; // Addresses alias every 1 KiB

	always_ff @(posedge clk) begin
		if (we_i) begin
			ram_q[idx] <= wdata_i;
		end
		rdata_o <= ram_q[idx]; // Old contents on a write to the same byte
	end

endmodule

`default_nettype wire

// File: hdl/ex_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module ex_mem (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    stall_i,
	input  wire mem_pkg::ex_mem_t  ex_i,
	output mem_pkg::ex_mem_t       mem_o
);

	// The held instruction keeps address and store data steady for every byte beat
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_o.opcode <= mem_pkg::OP_NONE; // Nothing in the stage after reset
			mem_o.wreg <= 1'b0;
			mem_o.wd <= `NOP_REG_ADDR;
		end else if (!stall_i) begin
			mem_o <= ex_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem (
	input  wire                    clk,
	input  wire                    rst,
	input  wire mem_pkg::ex_mem_t  mem_i,
	input  wire [`BYTE_W-1:0]      rdata_i,
	output mem_pkg::mem_wb_t       res_o,
	output logic                   stall_o,
	output logic [`ADDR_W-1:0]     addr_o,
	output logic                   we_o,
	output logic [`BYTE_W-1:0]     wdata_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_DRAIN,
		ST_DONE
	} state_e;

	state_e state_q;
	logic [2:0] beat_q; // Offset of the next byte address, counts on through the drain
	logic [3:0][`BYTE_W-1:0] load_bytes_q;
	logic is_load;
	logic is_store;
	logic done;
	logic issue;
	logic capture;
	logic [2:0] nbytes;
	logic [2:0] rcv_idx;
	logic [`REG_W-1:0] load_data;

	assign is_load = (mem_i.opcode == mem_pkg::OP_LOAD);
	assign is_store = (mem_i.opcode == mem_pkg::OP_STORE);
	assign done = (state_q == ST_DONE);

	// Request stays up until the done cycle
	assign stall_o = (is_load || is_store) && !done;

	always_comb begin
		case (mem_i.funct3)
			mem_pkg::F3_B, mem_pkg::F3_BU: nbytes = 3'd1;
			mem_pkg::F3_H, mem_pkg::F3_HU: nbytes = 3'd2;
			default: nbytes = 3'd4;
		endcase
	end

	// A new byte address goes out on the first cycle and while offsets remain
	assign issue = ((state_q == ST_IDLE) && stall_o) ||
		((state_q == ST_ISSUE) && (beat_q != nbytes));

	// Read data shows up two cycles after its address was registered
	assign rcv_idx = beat_q - 3'd2;
	assign capture = is_load &&
		(((state_q == ST_ISSUE) && (beat_q >= 3'd2)) || (state_q == ST_DRAIN));

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			beat_q <= '0;
			we_o <= 1'b0;
		end else begin
			we_o <= issue && is_store;
			case (state_q)
				ST_IDLE: begin
					if (stall_o) begin
						state_q <= ST_ISSUE;
						beat_q <= 3'd1;
					end
				end
				ST_ISSUE: begin
					if (beat_q == nbytes) begin
						if (is_store) begin
							state_q <= ST_DONE; // Last byte is written on this edge
						end else begin
							state_q <= ST_DRAIN;
						end
					end
					beat_q <= beat_q + 3'd1;
				end
				ST_DRAIN: begin
					if (rcv_idx == nbytes - 3'd1) begin
						state_q <= ST_DONE;
					end
					beat_q <= beat_q + 3'd1;
				end
				default: begin
					state_q <= ST_IDLE;
					beat_q <= '0;
				end
			endcase
		end
	end

	// Byte lanes of the store data go out lowest address first
	always_ff @(posedge clk) begin
		if (issue) begin
			addr_o <= mem_i.mem_addr + `ADDR_W'(beat_q);
			wdata_o <= mem_i.wdata[beat_q[1:0]*`BYTE_W +: `BYTE_W];
		end
		if (capture) begin
			load_bytes_q[rcv_idx[1:0]] <= rdata_i;
		end
	end

	always_comb begin
		case (mem_i.funct3)
			mem_pkg::F3_B: begin
				load_data = {{(`REG_W-`BYTE_W){load_bytes_q[0][`BYTE_W-1]}}, load_bytes_q[0]};
			end
			mem_pkg::F3_BU: begin
				load_data = {{(`REG_W-`BYTE_W){1'b0}}, load_bytes_q[0]};
			end
			mem_pkg::F3_H: begin
				load_data = {{(`REG_W-2*`BYTE_W){load_bytes_q[1][`BYTE_W-1]}},
					load_bytes_q[1], load_bytes_q[0]};
			end
			mem_pkg::F3_HU: begin
				load_data = {{(`REG_W-2*`BYTE_W){1'b0}}, load_bytes_q[1], load_bytes_q[0]};
			end
			default: begin
				load_data = load_bytes_q; // Byte 0 sits in the low lane
			end
		endcase
	end

	always_comb begin
		res_o.wd = mem_i.wd;
		res_o.wreg = mem_i.wreg;
		res_o.wdata = is_load ? load_data : mem_i.wdata;
	end

endmodule

`default_nettype wire

// File: hdl/mem_pkg.sv
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

	// RV32I major opcodes seen by this stage
	typedef enum logic [6:0] {
		OP_NONE    = 7'b0000000,
		OP_LOAD    = 7'b0000011,
		OP_ALU_IMM = 7'b0010011,
		OP_STORE   = 7'b0100011,
		OP_ALU     = 7'b0110011
	} opcode_e;

	// Width field of loads and stores
	typedef enum logic [2:0] {
		F3_B  = 3'b000,
		F3_H  = 3'b001,
		F3_W  = 3'b010,
		F3_BU = 3'b100,
		F3_HU = 3'b101
	} funct3_e;

	typedef struct packed {
		opcode_e                opcode;
		funct3_e                funct3;
		logic [`REG_ADDR_W-1:0] wd;
		logic                   wreg;
		logic [`REG_W-1:0]      wdata; // ALU result, store data for stores
		logic [`ADDR_W-1:0]     mem_addr;
	} ex_mem_t;

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] wd;
		logic                   wreg;
		logic [`REG_W-1:0]      wdata;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: hdl/mem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_stage_top (
	input  wire                    clk,
	input  wire                    rst,
	input  wire mem_pkg::ex_mem_t  ex_i,
	output mem_pkg::mem_wb_t       wb_o,
	output logic                   stall_o
);

	mem_pkg::ex_mem_t mem_in;
	mem_pkg::mem_wb_t res;
	logic stall;
	logic [`ADDR_W-1:0] ram_addr;
	logic ram_we;
	logic [`BYTE_W-1:0] ram_wdata;
	logic [`BYTE_W-1:0] ram_rdata;

	assign stall_o = stall;

	ex_mem u_ex_mem (
		.clk(clk),
		.rst(rst),
		.stall_i(stall),
		.ex_i(ex_i),
		.mem_o(mem_in)
	);

	mem u_mem (
		.clk(clk),
		.rst(rst),
		.mem_i(mem_in),
		.rdata_i(ram_rdata),
		.res_o(res),
		.stall_o(stall),
		.addr_o(ram_addr),
		.we_o(ram_we),
		.wdata_o(ram_wdata)
	);

	mem_wb u_mem_wb (
		.clk(clk),
		.rst(rst),
		.stall_i(stall),
		.res_i(res),
		.wb_o(wb_o)
	);

	byte_ram u_byte_ram (
		.clk(clk),
		.addr_i(ram_addr),
		.we_i(ram_we),
		.wdata_i(ram_wdata),
		.rdata_o(ram_rdata)
	);

endmodule

`default_nettype wire

// File: hdl/mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_wb (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    stall_i,
	input  wire mem_pkg::mem_wb_t  res_i,
	output mem_pkg::mem_wb_t       wb_o
);

	mem_pkg::mem_wb_t bubble;

	// An empty slot that writes no register
	assign bubble = '{wd: `NOP_REG_ADDR, wreg: 1'b0, wdata: '0};

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_o <= bubble;
		end else if (stall_i) begin
			wb_o <= bubble; // Keep writeback from seeing a half-finished access
		end else begin
			wb_o <= res_i;
		end
	end

endmodule

`default_nettype wire

// File: include/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Register side of the pipeline
`define REG_W 32
`define REG_ADDR_W 5

// Destination used by a bubble, never written back
`define NOP_REG_ADDR `REG_ADDR_W'(0)

// Byte address as produced by the ALU
`define ADDR_W 32

// The data memory moves one byte per access
`define BYTE_W 8

// 1 KiB of RAM, upper address bits wrap
`define RAM_DEPTH_LOG2 10

`endif

// File: sim/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module tb_mem_stage;

	localparam int TIMEOUT_CYCLES = 40;

	logic clk;
	logic rst;
	mem_pkg::ex_mem_t ex_i;
	mem_pkg::mem_wb_t wb_o;
	logic stall_o;
	logic [31:0] rng_state;
	logic [`BYTE_W-1:0] model_q [0:(1 << `RAM_DEPTH_LOG2)-1]; // Mirror of every store

	mem_stage_top dut0 (
		.clk(clk),
		.rst(rst),
		.ex_i(ex_i),
		.wb_o(wb_o),
		.stall_o(stall_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic mem_pkg::ex_mem_t make_op(input mem_pkg::opcode_e opcode,
		input mem_pkg::funct3_e funct3, input logic [`REG_ADDR_W-1:0] wd, input logic wreg,
		input logic [`REG_W-1:0] wdata, input logic [`ADDR_W-1:0] addr);
		mem_pkg::ex_mem_t op;
		op.opcode = opcode;
		op.funct3 = funct3;
		op.wd = wd;
		op.wreg = wreg;
		op.wdata = wdata;
		op.mem_addr = addr;
		return op;
	endfunction

	function automatic int width_bytes(input mem_pkg::funct3_e f3);
		case (f3)
			mem_pkg::F3_B, mem_pkg::F3_BU: return 1;
			mem_pkg::F3_H, mem_pkg::F3_HU: return 2;
			default: return 4;
		endcase
	endfunction

	// Cycles with the request high for each width
	function automatic int stall_cycles(input mem_pkg::ex_mem_t op);
		if (op.opcode == mem_pkg::OP_LOAD) begin
			return (width_bytes(op.funct3) == 4) ? 6 : width_bytes(op.funct3) + 2;
		end else if (op.opcode == mem_pkg::OP_STORE) begin
			return (width_bytes(op.funct3) == 4) ? 5 : width_bytes(op.funct3) + 1;
		end
		return 0;
	endfunction

	function automatic logic [`BYTE_W-1:0] byte_at(input logic [`ADDR_W-1:0] addr);
		return model_q[addr[`RAM_DEPTH_LOG2-1:0]]; // Upper bits wrap like the RAM
	endfunction

	function automatic logic [`REG_W-1:0] predict_load(input mem_pkg::funct3_e f3,
		input logic [`ADDR_W-1:0] addr);
		logic [3:0][7:0] b;
		int i;
		for (i = 0; i < 4; i++) begin
			b[i] = byte_at(addr + 32'(i));
		end
		case (f3)
			mem_pkg::F3_B: return {{24{b[0][7]}}, b[0]};
			mem_pkg::F3_BU: return {24'h0, b[0]};
			mem_pkg::F3_H: return {{16{b[1][7]}}, b[1], b[0]};
			mem_pkg::F3_HU: return {16'h0, b[1], b[0]};
			default: return {b[3], b[2], b[1], b[0]}; // Lowest address in the low byte
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic timeout_abort(input string what);
		$display("timed out waiting for %s", what);
		$display("FAIL: see errors above");
		$fatal(1, "stopped on a timeout");
	endtask

	// A stalled cycle leaves an empty slot in the write-back register
	task automatic check_bubble(input string name);
		check_value({name, " bubble wreg"}, 32'd0, 32'(wb_o.wreg));
		check_value({name, " bubble wd"}, 32'(`NOP_REG_ADDR), 32'(wb_o.wd));
		check_value({name, " bubble wdata"}, 32'd0, wb_o.wdata);
	endtask

	task automatic issue_op(input string name, input mem_pkg::ex_mem_t op);
		int n;
		n = 0;
		@(negedge clk);
		while (stall_o) begin
			n++;
			if (n > TIMEOUT_CYCLES) begin
				timeout_abort({"stall_o low before ", name});
			end
			@(negedge clk);
		end
		@(posedge clk);
		ex_i <= op;
		@(posedge clk);
		ex_i <= make_op(mem_pkg::OP_NONE, mem_pkg::F3_B, `NOP_REG_ADDR, 1'b0, '0, '0);
	endtask

	task automatic count_stall(input string name, output int n);
		n = 0;
		@(negedge clk);
		while (stall_o) begin
			n++;
			if (n > TIMEOUT_CYCLES) begin
				timeout_abort({"the end of the access in ", name});
			end
			@(negedge clk);
			check_bubble(name);
		end
	endtask

	task automatic collect_wb(input string name, output mem_pkg::mem_wb_t res,
		output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				timeout_abort({"a write-back from ", name});
			end
		end while (!wb_o.wreg);
		res = wb_o;
	endtask

	// Issue one op, check its stall length and the write-back that follows the done cycle
	task automatic exec_op(input string name, input mem_pkg::ex_mem_t op,
		output logic [`REG_W-1:0] wdata);
		int n;
		mem_pkg::mem_wb_t res;
		issue_op(name, op);
		count_stall(name, n);
		check_value({name, " stall"}, 32'(stall_cycles(op)), 32'(n));
		@(negedge clk);
		res = wb_o;
		check_value({name, " wreg"}, 32'(op.wreg), 32'(res.wreg));
		if (op.wreg) begin
			check_value({name, " wd"}, 32'(op.wd), 32'(res.wd));
		end
		wdata = res.wdata;
	endtask

	task automatic store_op(input string name, input mem_pkg::funct3_e f3,
		input logic [31:0] addr, input logic [31:0] data, input logic wreg);
		logic [31:0] got;
		logic [31:0] a;
		int i;
		for (i = 0; i < width_bytes(f3); i++) begin
			a = addr + 32'(i);
			model_q[a[`RAM_DEPTH_LOG2-1:0]] = data[8*i +: 8];
		end
		exec_op(name, make_op(mem_pkg::OP_STORE, f3, 5'd3, wreg, data, addr), got);
		if (wreg) begin
			check_value({name, " data"}, data, got);
		end
	endtask

	task automatic load_op(input string name, input mem_pkg::funct3_e f3,
		input logic [31:0] addr, output logic [31:0] value);
		logic [31:0] expected;
		expected = predict_load(f3, addr);
		exec_op(name, make_op(mem_pkg::OP_LOAD, f3, 5'd9, 1'b1, 32'hcccc_cccc, addr), value);
		check_value(name, expected, value);
	endtask

	task automatic reset_and_alu();
		mem_pkg::mem_wb_t res;
		int cycles;
		@(negedge clk);
		check_value("reset stall_o", 32'd0, 32'(stall_o));
		check_value("reset wreg", 32'd0, 32'(wb_o.wreg));
		issue_op("alu", make_op(mem_pkg::OP_ALU, mem_pkg::F3_B, 5'd7, 1'b1, 32'hdead_beef, '0));
		collect_wb("alu", res, cycles);
		check_value("alu latency", 32'd2, 32'(cycles)); // Two edges after the drive edge
		check_value("alu wd", 32'd7, 32'(res.wd));
		check_value("alu wdata", 32'hdead_beef, res.wdata);
	endtask

	task automatic word_and_bytes();
		logic [31:0] value;
		int i;
		store_op("sw word", mem_pkg::F3_W, 32'h040, 32'h80f1_7e05, 1'b0);
		load_op("lw word", mem_pkg::F3_W, 32'h040, value);
		check_value("lw literal", 32'h80f1_7e05, value);
		for (i = 0; i < 4; i++) begin
			load_op($sformatf("lb offset %0d", i), mem_pkg::F3_B, 32'h040 + 32'(i), value);
			load_op($sformatf("lbu offset %0d", i), mem_pkg::F3_BU, 32'h040 + 32'(i), value);
		end
	endtask

	task automatic partial_stores();
		logic [31:0] value;
		store_op("sw base", mem_pkg::F3_W, 32'h080, 32'h1122_3344, 1'b0);
		store_op("sb middle", mem_pkg::F3_B, 32'h081, 32'h0000_00aa, 1'b0);
		load_op("lw after sb", mem_pkg::F3_W, 32'h080, value);
		check_value("sb lanes", 32'h1122_aa44, value);
		store_op("sh upper", mem_pkg::F3_H, 32'h082, 32'h0000_beef, 1'b0);
		load_op("lw after sh", mem_pkg::F3_W, 32'h080, value);
		check_value("sh lanes", 32'hbeef_aa44, value);
		load_op("lh negative", mem_pkg::F3_H, 32'h082, value);
		check_value("lh extend", 32'hffff_beef, value);
		load_op("lhu negative", mem_pkg::F3_HU, 32'h082, value);
		check_value("lhu extend", 32'h0000_beef, value);
	endtask

	task automatic stall_lengths();
		logic [31:0] value;
		store_op("sb timing", mem_pkg::F3_B, 32'h0c0, 32'h0000_005a, 1'b1);
		store_op("sh timing", mem_pkg::F3_H, 32'h0c2, 32'h0000_a55a, 1'b0);
		store_op("sw timing", mem_pkg::F3_W, 32'h0c4, 32'h1234_5678, 1'b1);
		load_op("lb timing", mem_pkg::F3_B, 32'h0c0, value);
		load_op("lbu timing", mem_pkg::F3_BU, 32'h0c2, value);
		load_op("lh timing", mem_pkg::F3_H, 32'h0c2, value);
		load_op("lhu timing", mem_pkg::F3_HU, 32'h0c4, value);
		load_op("lw timing", mem_pkg::F3_W, 32'h0c4, value);
		exec_op("alu_imm timing",
			make_op(mem_pkg::OP_ALU_IMM, mem_pkg::F3_B, 5'd12, 1'b1, 32'h0bad_f00d, '0), value);
		check_value("alu_imm wdata", 32'h0bad_f00d, value);
	endtask

	task automatic random_traffic();
		logic [31:0] r;
		logic [31:0] data;
		logic [31:0] addr;
		logic [31:0] value;
		string name;
		int i;
		for (i = 0; i < 16; i++) begin
			rng_state = xorshift32(rng_state);
			store_op($sformatf("fill %0d", i), mem_pkg::F3_W, 32'h100 + 32'(4*i), rng_state, 1'b0);
		end
		for (i = 0; i < 40; i++) begin
			rng_state = xorshift32(rng_state);
			r = rng_state;
			rng_state = xorshift32(rng_state);
			data = rng_state;
			addr = {r[31:10], 10'h100 | {4'h0, r[5:0]}}; // High bits only alias the filled block
			name = $sformatf("random %0d", i);
			case (r[8:6])
				3'd0: load_op(name, mem_pkg::F3_B, addr, value);
				3'd1: load_op(name, mem_pkg::F3_BU, addr, value);
				3'd2: load_op(name, mem_pkg::F3_H, {addr[31:1], 1'b0}, value);
				3'd3: load_op(name, mem_pkg::F3_HU, {addr[31:1], 1'b0}, value);
				3'd4: load_op(name, mem_pkg::F3_W, {addr[31:2], 2'b00}, value);
				3'd5: store_op(name, mem_pkg::F3_B, addr, data, r[9]);
				3'd6: store_op(name, mem_pkg::F3_H, {addr[31:1], 1'b0}, data, r[9]);
				default: store_op(name, mem_pkg::F3_W, {addr[31:2], 2'b00}, data, r[9]);
			endcase
		end
	endtask

	initial begin
		rst = 1'b1;
		ex_i = make_op(mem_pkg::OP_NONE, mem_pkg::F3_B, `NOP_REG_ADDR, 1'b0, '0, '0);
		rng_state = 32'h58b5e296;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		reset_and_alu();
		word_and_bytes();
		partial_stores();
		stall_lengths();
		random_traffic();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire
